//--- ice_defs.svh
`ifndef ICE_DEFS_SVH
`define ICE_DEFS_SVH

// Command bytes
`define ICE_CMD_VERSION    8'h76
`define ICE_CMD_Q_I2C      8'h49
`define ICE_CMD_S_I2C      8'h69
`define ICE_CMD_Q_GPIO     8'h47
`define ICE_CMD_S_GPIO     8'h67

// Selector bytes that follow the length byte
`define ICE_SEL_SPEED      8'h63
`define ICE_SEL_ADDR       8'h61
`define ICE_SEL_LEVEL      8'h6C
`define ICE_SEL_DIR        8'h64

// Status byte at the head of each response
`define ICE_ACK            8'h01
`define ICE_NAK            8'h00

// Built-in version
`define ICE_VER_MAJOR      8'h00
`define ICE_VER_MINOR      8'h02

// Settings after reset
`define ICE_I2C_SPEED_RST  8'd99
`define ICE_I2C_ADDR_RST   16'hFFFF
`define ICE_GPIO_RST       24'h000000

// Response FIFO entries
`define ICE_RESP_DEPTH     16

`endif

//--- ice_pkg.sv
package ice_pkg;

	// One cycle of the master input stream
	typedef struct packed {
		logic [7:0] data;
		logic       data_valid;
		logic       frame_valid;
	} in_beat_t;

	// Commands recognized on the command byte
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_VERSION,
		CMD_Q_I2C,
		CMD_S_I2C,
		CMD_Q_GPIO,
		CMD_S_GPIO,
		CMD_NAK
	} cmd_kind_t;

	// Frame header handed to the engine
	typedef struct packed {
		cmd_kind_t  kind;
		logic [7:0] eid;
	} cmd_hdr_t;

	// Setting slots; gpio read is query only
	typedef enum logic [2:0] {
		SEL_I2C_SPEED,
		SEL_I2C_ADDR,
		SEL_GPIO_LEVEL,
		SEL_GPIO_DIR,
		SEL_GPIO_READ
	} param_sel_t;

	// Response byte with end of frame flag
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} resp_beat_t;

endpackage

//--- frame_intake.sv
`include "ice_defs.svh"

module frame_intake (
	input  logic              clk,
	input  logic              rst,
	input  ice_pkg::in_beat_t in_beat,
	input  logic              generate_nak,
	output logic              hdr_valid,
	output ice_pkg::cmd_hdr_t hdr,
	output logic              pay_valid,
	output logic [7:0]        pay_data
);
	import ice_pkg::*;

	logic       prev_fv;
	logic       frame_start;
	logic       active;
	// Byte position in frame: 1 EID, 2 length, 3 payload
	logic [1:0] pos;
	cmd_kind_t  kind_dec;

	assign frame_start = in_beat.frame_valid && !prev_fv;

	// Command byte decode, immediate NAK wins
	always_comb begin
		if (generate_nak) begin
			kind_dec = CMD_NAK;
		end else begin
			case (in_beat.data)
				`ICE_CMD_VERSION: kind_dec = CMD_VERSION;
				`ICE_CMD_Q_I2C:   kind_dec = CMD_Q_I2C;
				`ICE_CMD_S_I2C:   kind_dec = CMD_S_I2C;
				`ICE_CMD_Q_GPIO:  kind_dec = CMD_Q_GPIO;
				`ICE_CMD_S_GPIO:  kind_dec = CMD_S_GPIO;
				default:          kind_dec = CMD_NONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prev_fv   <= 1'b0;
			active    <= 1'b0;
			pos       <= 2'd0;
			hdr_valid <= 1'b0;
			pay_valid <= 1'b0;
		end else begin
			prev_fv   <= in_beat.frame_valid;
			hdr_valid <= 1'b0;
			pay_valid <= 1'b0;
			if (frame_start) begin
				active <= (kind_dec != CMD_NONE);
				pos    <= 2'd1;
			end else if (!in_beat.frame_valid) begin
				active <= 1'b0;
				pos    <= 2'd0;
			end else if (in_beat.data_valid) begin
				case (pos)
					2'd1: begin
						hdr_valid <= active;
						pos       <= 2'd2;
					end
					// Length byte is not needed downstream
					2'd2: pos <= 2'd3;
					2'd3: pay_valid <= active;
					default: pos <= 2'd0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start) begin
			hdr.kind <= kind_dec;
		end
		if (in_beat.frame_valid && in_beat.data_valid && !frame_start && pos == 2'd1) begin
			hdr.eid <= in_beat.data;
		end
		pay_data <= in_beat.data;
	end

	a_dv_in_frame: assert property (@(posedge clk) disable iff (rst)
		$rose(in_beat.data_valid) |-> in_beat.frame_valid)
		else $error("data_valid rose outside a frame");

endmodule

//--- param_bank.sv
`include "ice_defs.svh"

module param_bank (
	input  logic                clk,
	input  logic                rst,
	input  logic                sel_valid,
	input  ice_pkg::param_sel_t sel,
	input  logic                wr_byte_valid,
	input  logic [7:0]          wr_byte,
	input  logic                commit,
	input  logic                rd_next,
	input  logic [23:0]         gpio_read,
	output logic [7:0]          rd_byte,
	output logic [1:0]          sel_len,
	output logic [7:0]          i2c_speed,
	output logic [15:0]         i2c_addr,
	output logic [23:0]         gpio_level,
	output logic [23:0]         gpio_direction
);
	import ice_pkg::*;

	param_sel_t  sel_q;
	logic [23:0] rd_stage;
	logic [23:0] wr_stage;

	// Query bytes leave from the top, MSB first
	assign rd_byte = rd_stage[23:16];

	always_comb begin
		case (sel_q)
			SEL_I2C_SPEED: sel_len = 2'd1;
			SEL_I2C_ADDR:  sel_len = 2'd2;
			default:       sel_len = 2'd3;
		endcase
	end

	// Read staging, left aligned so short slots also start at the top byte
	always_ff @(posedge clk) begin
		if (sel_valid) begin
			case (sel)
				SEL_I2C_SPEED:  rd_stage <= {i2c_speed, 16'h0000};
				SEL_I2C_ADDR:   rd_stage <= {i2c_addr, 8'h00};
				SEL_GPIO_LEVEL: rd_stage <= gpio_level;
				SEL_GPIO_DIR:   rd_stage <= gpio_direction;
				default:        rd_stage <= gpio_read;
			endcase
		end else if (rd_next) begin
			rd_stage <= {rd_stage[15:0], 8'h00};
		end
	end

	// Write staging keeps the last three bytes received
	always_ff @(posedge clk) begin
		if (sel_valid) begin
			wr_stage <= '0;
		end else if (wr_byte_valid) begin
			wr_stage <= {wr_stage[15:0], wr_byte};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q          <= SEL_I2C_SPEED;
			i2c_speed      <= `ICE_I2C_SPEED_RST;
			i2c_addr       <= `ICE_I2C_ADDR_RST;
			gpio_level     <= `ICE_GPIO_RST;
			gpio_direction <= `ICE_GPIO_RST;
		end else begin
			if (sel_valid) begin
				sel_q <= sel;
			end
			if (commit) begin
				case (sel_q)
					SEL_I2C_SPEED:  i2c_speed      <= wr_stage[7:0];
					SEL_I2C_ADDR:   i2c_addr       <= wr_stage[15:0];
					SEL_GPIO_LEVEL: gpio_level     <= wr_stage;
					SEL_GPIO_DIR:   gpio_direction <= wr_stage;
					default:        gpio_level     <= gpio_level;
				endcase
			end
		end
	end

	a_no_commit_read: assert property (@(posedge clk) disable iff (rst)
		commit |-> sel_q != SEL_GPIO_READ)
		else $error("commit with the read-only gpio slot selected");

endmodule

//--- command_engine.sv
`include "ice_defs.svh"

module command_engine (
	input  logic                clk,
	input  logic                rst,
	input  logic                hdr_valid,
	input  ice_pkg::cmd_hdr_t   hdr,
	input  logic                pay_valid,
	input  logic [7:0]          pay_data,
	input  logic [7:0]          rd_byte,
	input  logic [1:0]          sel_len,
	output logic                sel_valid,
	output ice_pkg::param_sel_t sel,
	output logic                wr_byte_valid,
	output logic [7:0]          wr_byte,
	output logic                commit,
	output logic                rd_next,
	output logic                push,
	output ice_pkg::resp_beat_t push_beat,
	input  logic                full,
	input  logic                empty
);
	import ice_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_VER, S_SEL, S_SET, S_EMIT, S_WAIT} state_t;
	// Response shape chosen before emitting
	typedef enum logic [1:0] {R_NAK, R_ACK, R_VER_NAK, R_QUERY} resp_t;

	state_t     state;
	resp_t      resp;
	cmd_kind_t  kind_q;
	logic [7:0] eid_q;
	logic [7:0] ver_hi;
	logic       ver_cnt;
	logic [1:0] wr_cnt;
	logic [2:0] idx;
	logic       is_set;
	logic       sel_known;
	param_sel_t sel_dec;
	logic [1:0] resp_len;
	logic       last_byte;

	assign is_set = (kind_q == CMD_S_I2C) || (kind_q == CMD_S_GPIO);

	// Selector byte to slot; "l" is gpio_read on a query, level on a set
	always_comb begin
		sel_known = 1'b1;
		sel_dec   = SEL_I2C_SPEED;
		if (kind_q == CMD_Q_I2C || kind_q == CMD_S_I2C) begin
			if (pay_data == `ICE_SEL_SPEED) sel_dec = SEL_I2C_SPEED;
			else if (pay_data == `ICE_SEL_ADDR) sel_dec = SEL_I2C_ADDR;
			else sel_known = 1'b0;
		end else begin
			if (pay_data == `ICE_SEL_LEVEL) sel_dec = is_set ? SEL_GPIO_LEVEL : SEL_GPIO_READ;
			else if (pay_data == `ICE_SEL_DIR) sel_dec = SEL_GPIO_DIR;
			else sel_known = 1'b0;
		end
	end

	assign sel_valid     = (state == S_SEL) && pay_valid && sel_known;
	assign sel           = sel_dec;
	assign wr_byte_valid = (state == S_SET) && pay_valid;
	assign wr_byte       = pay_data;
	assign commit        = (state == S_WAIT) && empty;

	always_comb begin
		case (resp)
			R_VER_NAK: resp_len = 2'd2;
			R_QUERY:   resp_len = sel_len;
			default:   resp_len = 2'd0;
		endcase
	end

	// Status, EID, length, then payload
	assign last_byte = (idx == 3'd2 + {1'b0, resp_len});
	assign push      = (state == S_EMIT) && !full;
	assign rd_next   = push && (resp == R_QUERY) && (idx >= 3'd3);

	always_comb begin
		case (idx)
			3'd0: push_beat.data = (resp == R_ACK || resp == R_QUERY) ? `ICE_ACK : `ICE_NAK;
			3'd1: push_beat.data = eid_q;
			3'd2: push_beat.data = {6'd0, resp_len};
			3'd3: push_beat.data = (resp == R_VER_NAK) ? `ICE_VER_MAJOR : rd_byte;
			default: push_beat.data = (resp == R_VER_NAK) ? `ICE_VER_MINOR : rd_byte;
		endcase
		push_beat.last = last_byte;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= S_IDLE;
			resp    <= R_NAK;
			kind_q  <= CMD_NONE;
			ver_cnt <= 1'b0;
			wr_cnt  <= 2'd0;
			idx     <= 3'd0;
		end else begin
			case (state)
				S_IDLE: begin
					idx     <= 3'd0;
					ver_cnt <= 1'b0;
					wr_cnt  <= 2'd0;
					if (hdr_valid) begin
						kind_q <= hdr.kind;
						case (hdr.kind)
							CMD_NAK: begin
								resp  <= R_NAK;
								state <= S_EMIT;
							end
							CMD_VERSION: state <= S_VER;
							CMD_NONE:    state <= S_IDLE;
							default:     state <= S_SEL;
						endcase
					end
				end
				S_VER: begin
					if (pay_valid && !ver_cnt) begin
						ver_cnt <= 1'b1;
					end else if (pay_valid) begin
						resp  <= ({ver_hi, pay_data} == {`ICE_VER_MAJOR, `ICE_VER_MINOR}) ?
							R_ACK : R_VER_NAK;
						state <= S_EMIT;
					end
				end
				S_SEL: begin
					if (pay_valid && !sel_known) begin
						resp  <= R_NAK;
						state <= S_EMIT;
					end else if (pay_valid && is_set) begin
						state <= S_SET;
					end else if (pay_valid) begin
						resp  <= R_QUERY;
						state <= S_EMIT;
					end
				end
				// Value bytes, MSB first, as many as the slot is wide
				S_SET: begin
					if (pay_valid && wr_cnt == sel_len - 2'd1) begin
						resp  <= R_ACK;
						state <= S_EMIT;
					end else if (pay_valid) begin
						wr_cnt <= wr_cnt + 2'd1;
					end
				end
				S_EMIT: begin
					if (push && last_byte) begin
						idx   <= 3'd0;
						state <= (is_set && resp == R_ACK) ? S_WAIT : S_IDLE;
					end else if (push) begin
						idx <= idx + 3'd1;
					end
				end
				// Hold the new setting back until the ACK has drained
				S_WAIT: begin
					if (empty) state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && hdr_valid) eid_q <= hdr.eid;
		if (state == S_VER && pay_valid && !ver_cnt) ver_hi <= pay_data;
	end

	// Only one frame in flight, so a header finds the engine idle
	a_hdr_when_idle: assert property (@(posedge clk) disable iff (rst)
		hdr_valid |-> state == S_IDLE)
		else $error("frame header arrived while a command was still in progress");

endmodule

//--- resp_queue.sv
`include "ice_defs.svh"

module resp_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  ice_pkg::resp_beat_t push_beat,
	output logic                full,
	output logic                empty,
	output ice_pkg::resp_beat_t out_beat,
	output logic                out_valid,
	input  logic                out_ready
);
	import ice_pkg::*;

	localparam int DEPTH = `ICE_RESP_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	resp_beat_t    mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [AW:0]   count;
	logic          wr_en;
	logic          rd_en;

	assign full      = (count == DEPTH);
	assign empty     = (count == 0);
	assign out_valid = !empty;
	assign out_beat  = mem[rptr];

	assign wr_en = push && !full;
	assign rd_en = out_valid && out_ready;

	// Storage, written at the tail
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wptr] <= push_beat;
		end
	end

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wptr <= wptr + 1'b1;
			end
			if (rd_en) begin
				rptr <= rptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// A push while full would be dropped
	a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("push into a full response queue");

endmodule

//--- basics_top.sv
module basics_top (
	input  logic                clk,
	input  logic                rst,
	input  ice_pkg::in_beat_t   in_beat,
	input  logic                generate_nak,
	input  logic [23:0]         gpio_read,
	output ice_pkg::resp_beat_t out_beat,
	output logic                out_valid,
	input  logic                out_ready,
	output logic [7:0]          i2c_speed,
	output logic [15:0]         i2c_addr,
	output logic [23:0]         gpio_level,
	output logic [23:0]         gpio_direction
);

	// Intake to engine
	logic                hdr_valid;
	ice_pkg::cmd_hdr_t   hdr;
	logic                pay_valid;
	logic [7:0]          pay_data;

	// Engine to settings
	logic                sel_valid;
	ice_pkg::param_sel_t sel;
	logic                wr_byte_valid;
	logic [7:0]          wr_byte;
	logic                commit;
	logic                rd_next;
	logic [7:0]          rd_byte;
	logic [1:0]          sel_len;

	// Engine to response queue
	logic                push;
	ice_pkg::resp_beat_t push_beat;
	logic                full;
	logic                empty;

	frame_intake u_intake (.*);

	command_engine u_engine (.*);

	param_bank u_params (.*);

	resp_queue u_queue (.*);

endmodule

//--- tb_checker.sv
module tb_checker (
	input  logic                clk,
	input  logic                rst,
	input  ice_pkg::resp_beat_t out_beat,
	input  logic                out_valid,
	input  logic                out_ready,
	input  logic [7:0]          i2c_speed,
	input  logic [15:0]         i2c_addr,
	input  logic [23:0]         gpio_level,
	input  logic [23:0]         gpio_direction,
	input  logic [7:0]          exp_speed,
	input  logic [15:0]         exp_addr,
	input  logic [23:0]         exp_level,
	input  logic [23:0]         exp_dir,
	output int                  errors,
	output int                  frames_seen
);
	import ice_pkg::*;

	// Expected bytes of frames still in flight, with their lengths and names
	logic [7:0]  exp_q [$];
	int          len_q [$];
	string       name_q [$];
	string       last_name;
	int          pos;
	int          settle;
	logic [71:0] held;
	logic        early_seen;

	initial begin
		errors      = 0;
		frames_seen = 0;
		pos         = 0;
		settle      = 0;
		last_name   = "none";
		early_seen  = 1'b0;
	end

	task automatic queue_expected(input string name, input int len, input logic [7:0] bytes [8]);
		len_q.push_back(len);
		name_q.push_back(name);
		for (int i = 0; i < len; i++) begin
			exp_q.push_back(bytes[i]);
		end
	endtask

	task automatic check_value(input string what, input logic [23:0] exp, input logic [23:0] act);
		if (act !== exp) begin
			$display("Mismatch %s %s: expected 0x%06h, actual 0x%06h", last_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic take_byte();
		int len;
		if (len_q.size() == 0) begin
			$display("Error: response byte 0x%02h arrived with no frame expected", out_beat.data);
			errors++;
		end else begin
			len = len_q[0];
			if (pos < len && out_beat.data !== exp_q[pos]) begin
				$display("Mismatch %s byte %0d: expected 0x%02h, actual 0x%02h",
					name_q[0], pos, exp_q[pos], out_beat.data);
				errors++;
			end else if (pos == len) begin
				$display("Error: %s response is longer than %0d bytes", name_q[0], len);
				errors++;
			end
			if (out_beat.last) begin
				if (pos + 1 < len) begin
					$display("Error: %s response ended after %0d of %0d bytes",
						name_q[0], pos + 1, len);
					errors++;
				end
				for (int i = 0; i < len; i++) begin
					void'(exp_q.pop_front());
				end
				last_name = name_q.pop_front();
				void'(len_q.pop_front());
				pos = 0;
				frames_seen++;
				// Settings may move up to two cycles after the last byte leaves
				settle = 4;
				early_seen = 1'b0;
			end else begin
				pos++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			if (out_valid === 1'b1) begin
				$display("Error: out_valid is high during reset");
				errors++;
			end
		end else begin
			// No setting may move while its response is still draining
			if (len_q.size() == 0) begin
				held = {i2c_speed, i2c_addr, gpio_level, gpio_direction};
			end else if (!early_seen &&
					held !== {i2c_speed, i2c_addr, gpio_level, gpio_direction}) begin
				$display("Error: %s changed a setting before its response finished", name_q[0]);
				errors++;
				early_seen = 1'b1;
			end
			if (out_valid && out_ready) begin
				take_byte();
			end
			if (settle == 1) begin
				check_value("i2c_speed", {16'h0000, exp_speed}, {16'h0000, i2c_speed});
				check_value("i2c_addr", {8'h00, exp_addr}, {8'h00, i2c_addr});
				check_value("gpio_level", exp_level, gpio_level);
				check_value("gpio_direction", exp_dir, gpio_direction);
			end
			if (settle > 0) begin
				settle--;
			end
		end
	end

endmodule

//--- tb_top.sv
`include "ice_defs.svh"

module tb_top;
	import ice_pkg::*;

	localparam int N_DIRECTED = 15;
	localparam int N_RANDOM   = 40;
	localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 200;

	logic        clk;
	logic        rst;
	in_beat_t    in_beat;
	logic        generate_nak;
	logic [23:0] gpio_read;
	resp_beat_t  out_beat;
	logic        out_valid;
	logic        out_ready;
	logic [7:0]  i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;

	// Shadow copy of the settings, kept by the reference function
	logic [7:0]  sh_speed;
	logic [15:0] sh_addr;
	logic [23:0] sh_level;
	logic [23:0] sh_dir;

	logic [7:0]  pay [4];
	int          seed;
	int          cycles = 0;
	int          sent;
	int          chk_errors;
	int          frames_seen;
	int          pick;
	logic [31:0] rv;
	logic [31:0] rv2;

	basics_top DUT (.*);

	tb_checker u_chk (
		.clk(clk), .rst(rst), .out_beat(out_beat), .out_valid(out_valid),
		.out_ready(out_ready), .i2c_speed(i2c_speed), .i2c_addr(i2c_addr),
		.gpio_level(gpio_level), .gpio_direction(gpio_direction),
		.exp_speed(sh_speed), .exp_addr(sh_addr), .exp_level(sh_level), .exp_dir(sh_dir),
		.errors(chk_errors), .frames_seen(frames_seen)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Error: timeout after %0d cycles, %0d of %0d responses seen",
				cycles, frames_seen, sent);
			$display("Errors: %0d", chk_errors + 1);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Random back-pressure, ready about three cycles in four
	always @(negedge clk) begin
		out_ready <= ($random(seed) & 3) != 0;
	end

	// Expected response from the command rules; updates the shadow on a set
	function automatic int ref_response(input logic [7:0] cmd, input logic nak,
			input logic [7:0] eid, input logic [7:0] p [4], input int p_len,
			input logic [23:0] gin, inout logic [7:0] speed, inout logic [15:0] addr,
			inout logic [23:0] level, inout logic [23:0] dir, output logic [7:0] r [8]);
		logic [23:0] val;
		int          len;
		for (int i = 0; i < 8; i++) begin
			r[i] = 8'h00;
		end
		val = 24'h000000;
		for (int i = 1; i < p_len; i++) begin
			val = {val[15:0], p[i]};
		end
		r[0] = `ICE_ACK;
		r[1] = eid;
		len  = 3;
		if (nak) begin
			r[0] = `ICE_NAK;
		end else if (cmd == `ICE_CMD_VERSION) begin
			if (!(p_len == 2 && p[0] == `ICE_VER_MAJOR && p[1] == `ICE_VER_MINOR)) begin
				r[0] = `ICE_NAK;
				{r[2], r[3], r[4]} = {8'd2, `ICE_VER_MAJOR, `ICE_VER_MINOR};
				len = 5;
			end
		end else if (cmd == `ICE_CMD_Q_I2C && p[0] == `ICE_SEL_SPEED) begin
			{r[2], r[3]} = {8'd1, speed};
			len = 4;
		end else if (cmd == `ICE_CMD_Q_I2C && p[0] == `ICE_SEL_ADDR) begin
			{r[2], r[3], r[4]} = {8'd2, addr};
			len = 5;
		end else if (cmd == `ICE_CMD_Q_GPIO && p[0] == `ICE_SEL_LEVEL) begin
			{r[2], r[3], r[4], r[5]} = {8'd3, gin};
			len = 6;
		end else if (cmd == `ICE_CMD_Q_GPIO && p[0] == `ICE_SEL_DIR) begin
			{r[2], r[3], r[4], r[5]} = {8'd3, dir};
			len = 6;
		end else if (cmd == `ICE_CMD_S_I2C && p[0] == `ICE_SEL_SPEED) begin
			speed = val[7:0];
		end else if (cmd == `ICE_CMD_S_I2C && p[0] == `ICE_SEL_ADDR) begin
			addr = val[15:0];
		end else if (cmd == `ICE_CMD_S_GPIO && p[0] == `ICE_SEL_LEVEL) begin
			level = val;
		end else if (cmd == `ICE_CMD_S_GPIO && p[0] == `ICE_SEL_DIR) begin
			dir = val;
		end else begin
			r[0] = `ICE_NAK;
		end
		return len;
	endfunction

	task automatic load_payload(input logic [7:0] b0, input logic [7:0] b1,
			input logic [7:0] b2, input logic [7:0] b3);
		pay[0] = b0;
		pay[1] = b1;
		pay[2] = b2;
		pay[3] = b3;
	endtask

	// One byte per two cycles, entered and left on a falling edge
	task automatic drive_byte(input logic [7:0] b);
		in_beat.data       = b;
		in_beat.data_valid = 1'b1;
		@(negedge clk);
		in_beat.data_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic send_frame(input string name, input logic [7:0] cmd, input logic nak,
			input logic [7:0] eid, input int p_len);
		logic [7:0] r [8];
		int         len;
		len = ref_response(cmd, nak, eid, pay, p_len, gpio_read,
			sh_speed, sh_addr, sh_level, sh_dir, r);
		u_chk.queue_expected(name, len, r);
		sent++;
		@(negedge clk);
		in_beat.frame_valid = 1'b1;
		generate_nak        = nak;
		drive_byte(cmd);
		generate_nak        = 1'b0;
		drive_byte(eid);
		drive_byte(p_len[7:0]);
		for (int i = 0; i < p_len; i++) begin
			drive_byte(pay[i]);
		end
		in_beat.frame_valid = 1'b0;
		wait (frames_seen == sent);
		repeat (4) @(negedge clk);
	endtask

	initial begin
		seed         = 90;
		rst          = 1'b1;
		in_beat      = '0;
		generate_nak = 1'b0;
		gpio_read    = 24'h000000;
		out_ready    = 1'b0;
		sent         = 0;
		sh_speed     = `ICE_I2C_SPEED_RST;
		sh_addr      = `ICE_I2C_ADDR_RST;
		sh_level     = `ICE_GPIO_RST;
		sh_dir       = `ICE_GPIO_RST;
		load_payload(8'h00, 8'h00, 8'h00, 8'h00);
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		rv  = $random(seed);
		rv2 = $random(seed);
		@(negedge clk);

		load_payload(`ICE_VER_MAJOR, `ICE_VER_MINOR, 8'h00, 8'h00);
		send_frame("version_match", `ICE_CMD_VERSION, 1'b0, 8'h11, 2);
		load_payload(8'h01, 8'h00, 8'h00, 8'h00);
		send_frame("version_other", `ICE_CMD_VERSION, 1'b0, 8'h12, 2);
		load_payload(`ICE_SEL_SPEED, 8'h00, 8'h00, 8'h00);
		send_frame("i2c_speed_reset", `ICE_CMD_Q_I2C, 1'b0, 8'h13, 1);
		load_payload(`ICE_SEL_ADDR, 8'h00, 8'h00, 8'h00);
		send_frame("i2c_addr_reset", `ICE_CMD_Q_I2C, 1'b0, 8'h14, 1);
		load_payload(`ICE_SEL_SPEED, rv[7:0], 8'h00, 8'h00);
		send_frame("i2c_speed_set", `ICE_CMD_S_I2C, 1'b0, 8'h15, 2);
		load_payload(`ICE_SEL_SPEED, 8'h00, 8'h00, 8'h00);
		send_frame("i2c_speed_query", `ICE_CMD_Q_I2C, 1'b0, 8'h16, 1);
		load_payload(`ICE_SEL_ADDR, rv[15:8], rv[23:16], 8'h00);
		send_frame("i2c_addr_set", `ICE_CMD_S_I2C, 1'b0, 8'h17, 3);
		load_payload(`ICE_SEL_ADDR, 8'h00, 8'h00, 8'h00);
		send_frame("i2c_addr_query", `ICE_CMD_Q_I2C, 1'b0, 8'h18, 1);
		load_payload(`ICE_SEL_LEVEL, rv2[23:16], rv2[15:8], rv2[7:0]);
		send_frame("gpio_level_set", `ICE_CMD_S_GPIO, 1'b0, 8'h19, 4);
		load_payload(`ICE_SEL_DIR, rv2[31:24], rv[31:24], rv2[7:0]);
		send_frame("gpio_dir_set", `ICE_CMD_S_GPIO, 1'b0, 8'h1A, 4);
		load_payload(`ICE_SEL_DIR, 8'h00, 8'h00, 8'h00);
		send_frame("gpio_dir_query", `ICE_CMD_Q_GPIO, 1'b0, 8'h1B, 1);
		gpio_read = rv2[31:8];
		load_payload(`ICE_SEL_LEVEL, 8'h00, 8'h00, 8'h00);
		send_frame("gpio_read_query", `ICE_CMD_Q_GPIO, 1'b0, 8'h1C, 1);
		load_payload(`ICE_SEL_LEVEL, 8'hAA, 8'hBB, 8'hCC);
		send_frame("forced_nak", `ICE_CMD_S_GPIO, 1'b1, 8'h1D, 4);
		load_payload(8'h7A, 8'h00, 8'h00, 8'h00);
		send_frame("i2c_bad_selector", `ICE_CMD_Q_I2C, 1'b0, 8'h1E, 1);
		load_payload(8'h7A, 8'h01, 8'h02, 8'h03);
		send_frame("gpio_bad_selector", `ICE_CMD_S_GPIO, 1'b0, 8'h1F, 4);

		// Mixed frames, drawn on a rising edge and driven on the next falling edge
		for (int k = 0; k < N_RANDOM; k++) begin
			@(posedge clk);
			pick = $random(seed) & 7;
			rv   = $random(seed);
			rv2  = $random(seed);
			@(negedge clk);
			gpio_read = rv2[23:0];
			case (pick)
				0: begin
					load_payload(`ICE_VER_MAJOR, rv[0] ? `ICE_VER_MINOR : rv[15:8], 8'h00, 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_VERSION, 1'b0, rv2[31:24], 2);
				end
				1: begin
					load_payload(rv[0] ? `ICE_SEL_SPEED : `ICE_SEL_ADDR, 8'h00, 8'h00, 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_Q_I2C, 1'b0, rv2[31:24], 1);
				end
				2: begin
					load_payload(`ICE_SEL_SPEED, rv[7:0], 8'h00, 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_S_I2C, 1'b0, rv2[31:24], 2);
				end
				3: begin
					load_payload(`ICE_SEL_ADDR, rv[15:8], rv[7:0], 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_S_I2C, 1'b0, rv2[31:24], 3);
				end
				4: begin
					load_payload(rv[0] ? `ICE_SEL_LEVEL : `ICE_SEL_DIR, 8'h00, 8'h00, 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_Q_GPIO, 1'b0, rv2[31:24], 1);
				end
				5: begin
					load_payload(rv[24] ? `ICE_SEL_LEVEL : `ICE_SEL_DIR, rv[23:16], rv[15:8], rv[7:0]);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_S_GPIO, 1'b0, rv2[31:24], 4);
				end
				6: begin
					load_payload(`ICE_SEL_SPEED, 8'h00, 8'h00, 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_Q_I2C, 1'b1, rv2[31:24], 1);
				end
				default: begin
					// Selectors are all below 0x80
					load_payload(rv[7:0] | 8'h80, 8'h00, 8'h00, 8'h00);
					send_frame($sformatf("random_%0d", k), `ICE_CMD_Q_GPIO, 1'b0, rv2[31:24], 1);
				end
			endcase
		end

		repeat (4) @(negedge clk);
		$display("Errors: %0d", chk_errors);
		if (chk_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+.
ice_pkg.sv
frame_intake.sv
param_bank.sv
command_engine.sv
resp_queue.sv
basics_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
FAIL_MSG  ?= FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o V$(TOP)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
